// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := tb_exec_core
FILELIST := src.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

lint:
	$(SIM) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/core_pkg.sv ====
package core_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 32;
    localparam int REG_AW    = $clog2(NUM_REGS);
    localparam int IMM_W     = 16;
    localparam int DUMP_BASE = 2;                  // First register in the debug dump
    localparam int DUMP_REGS = 4;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_ADDI = 4'd9,
        OP_MADD = 4'd10,                           // Three-operand ops from here on
        OP_MSUB = 4'd11,
        OP_CMOV = 4'd12
    } op_e;

    // True when the result comes from the MAC unit
    function automatic logic is_mac_op(input op_e op);
        return op inside {OP_MADD, OP_MSUB, OP_CMOV};
    endfunction

endpackage

// ==== design/exec_core.sv ====
`timescale 1ns/100ps

module exec_core #(
    parameter int XLEN = core_pkg::XLEN
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 issue,
    input  core_pkg::op_e                        op,
    input  logic [core_pkg::REG_AW-1:0]          rd,
    input  logic [core_pkg::REG_AW-1:0]          rs1,
    input  logic [core_pkg::REG_AW-1:0]          rs2,
    input  logic [core_pkg::REG_AW-1:0]          rs3,
    input  logic [core_pkg::IMM_W-1:0]           imm,
    output logic                                 wb_valid,
    output logic [core_pkg::REG_AW-1:0]          wb_rd,
    output logic [XLEN-1:0]                      wb_data,
    output logic [core_pkg::DUMP_REGS*XLEN-1:0]  register_dump
);

    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] rdata3;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mac_result;

    // Write port is fed straight from the writeback registers
    reg_file #(.XLEN(XLEN)) i_reg_file (
        .clk           (clk),
        .rst_n         (rst_n),
        .we            (wb_valid),
        .waddr         (wb_rd),
        .wdata         (wb_data),
        .raddr1        (rs1),
        .raddr2        (rs2),
        .raddr3        (rs3),
        .rdata1        (rdata1),
        .rdata2        (rdata2),
        .rdata3        (rdata3),
        .register_dump (register_dump)
    );

    int_alu #(.XLEN(XLEN)) i_int_alu (
        .op     (op),
        .a      (rdata1),
        .b      (rdata2),
        .imm    (imm),
        .result (alu_result)
    );

    mac_unit #(.XLEN(XLEN)) i_mac_unit (
        .op     (op),
        .a      (rdata1),
        .b      (rdata2),
        .c      (rdata3),
        .result (mac_result)
    );

    writeback_stage #(.XLEN(XLEN)) i_writeback_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .op         (op),
        .rd         (rd),
        .alu_result (alu_result),
        .mac_result (mac_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

// ==== design/int_alu.sv ====
`timescale 1ns/100ps

module int_alu #(
    parameter int XLEN = core_pkg::XLEN
) (
    input  core_pkg::op_e               op,
    input  logic [XLEN-1:0]             a,
    input  logic [XLEN-1:0]             b,
    input  logic [core_pkg::IMM_W-1:0]  imm,
    output logic [XLEN-1:0]             result
);

    import core_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    imm_ext;
    logic               lt;

    assign shamt   = b[SHAMT_W-1:0];                           // Upper bits of b ignored
    assign imm_ext = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    assign lt      = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            OP_ADD: begin
                result = a + b;
            end
            OP_SUB: begin
                result = a - b;
            end
            OP_AND: begin
                result = a & b;
            end
            OP_OR: begin
                result = a | b;
            end
            OP_XOR: begin
                result = a ^ b;
            end
            OP_SLL: begin
                result = a << shamt;
            end
            OP_SRL: begin
                result = a >> shamt;
            end
            OP_SRA: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            OP_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt};
            end
            OP_ADDI: begin
                result = a + imm_ext;
            end
            default: begin
                result = '0;                                   // MAC class
            end
        endcase
    end

endmodule

// ==== design/mac_unit.sv ====
`timescale 1ns/100ps

module mac_unit #(
    parameter int XLEN = core_pkg::XLEN
) (
    input  core_pkg::op_e    op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    input  logic [XLEN-1:0]  c,
    output logic [XLEN-1:0]  result
);

    import core_pkg::*;

    logic [XLEN-1:0] prod;

    // Only the low word of the product matters for either sign
    assign prod = a * b;

    always_comb begin
        case (op)
            OP_MADD: begin
                result = prod + c;
            end
            OP_MSUB: begin
                result = c - prod;
            end
            OP_CMOV: begin
                if (c != '0) begin
                    result = a;
                end else begin
                    result = b;
                end
            end
            default: begin
                result = '0;                   // ALU class
            end
        endcase
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/100ps

module reg_file #(
    parameter int XLEN = core_pkg::XLEN
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 we,
    input  logic [core_pkg::REG_AW-1:0]          waddr,
    input  logic [XLEN-1:0]                      wdata,
    input  logic [core_pkg::REG_AW-1:0]          raddr1,
    input  logic [core_pkg::REG_AW-1:0]          raddr2,
    input  logic [core_pkg::REG_AW-1:0]          raddr3,
    output logic [XLEN-1:0]                      rdata1,
    output logic [XLEN-1:0]                      rdata2,
    output logic [XLEN-1:0]                      rdata3,
    output logic [core_pkg::DUMP_REGS*XLEN-1:0]  register_dump
);

    import core_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // x0 reads zero and a write in flight is forwarded
    function automatic logic [XLEN-1:0] read_port(
        input logic [REG_AW-1:0] addr,
        input logic [XLEN-1:0]   stored
    );
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (we && addr == waddr) begin
            value = wdata;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin     // Writes to x0 are dropped
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1, regs[raddr1]);
        rdata2 = read_port(raddr2, regs[raddr2]);
        rdata3 = read_port(raddr3, regs[raddr3]);
    end

    // Highest register index lands in the top bits
    for (genvar g = 0; g < DUMP_REGS; g++) begin : g_dump
        assign register_dump[g*XLEN +: XLEN] = regs[DUMP_BASE+g];
    end

endmodule

// ==== design/writeback_stage.sv ====
`timescale 1ns/100ps

module writeback_stage #(
    parameter int XLEN = core_pkg::XLEN
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         issue,
    input  core_pkg::op_e                op,
    input  logic [core_pkg::REG_AW-1:0]  rd,
    input  logic [XLEN-1:0]              alu_result,
    input  logic [XLEN-1:0]              mac_result,
    output logic                         wb_valid,
    output logic [core_pkg::REG_AW-1:0]  wb_rd,
    output logic [XLEN-1:0]              wb_data
);

    import core_pkg::*;

    logic [XLEN-1:0] result_sel;

    assign result_sel = is_mac_op(op) ? mac_result : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue;                 // One-cycle pulse per instruction
        end
    end

    // Result and destination hold until the next issue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rd   <= '0;
            wb_data <= '0;
        end else if (issue) begin
            wb_rd   <= rd;
            wb_data <= result_sel;
        end
    end

endmodule

// ==== src.f ====
design/core_pkg.sv
design/reg_file.sv
design/int_alu.sv
design/mac_unit.sv
design/writeback_stage.sv
design/exec_core.sv
tb/exec_core_checker.sv
tb/tb_exec_core.sv

// ==== tb/exec_core_checker.sv ====
`timescale 1ns/100ps

module exec_core_checker #(
    parameter int XLEN = core_pkg::XLEN
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             issue,
    input  logic             wb_valid,
    input  logic [XLEN-1:0]  wb_data
);

    // Each issue gives exactly one writeback pulse one cycle later
    a_issue_to_wb: assert property (@(posedge clk) disable iff (!rst_n) issue |=> wb_valid)
        else $error("wb_valid missing one cycle after issue");

    a_no_extra_wb: assert property (@(posedge clk) disable iff (!rst_n) !issue |=> !wb_valid)
        else $error("wb_valid high without an issue in the previous cycle");

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !wb_valid)
        else $error("wb_valid high while in reset");

    a_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> !$isunknown(wb_data))
        else $error("wb_data has unknown bits during writeback");

endmodule

bind exec_core exec_core_checker #(.XLEN(XLEN)) i_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (issue),
    .wb_valid (wb_valid),
    .wb_data  (wb_data)
);

// ==== tb/tb_exec_core.sv ====
`timescale 1ns/100ps

module tb_exec_core;

    import core_pkg::*;

    localparam int CMP_W      = DUMP_REGS * XLEN;
    localparam int WB_TIMEOUT = 20;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       issue;
    op_e                        op;
    logic [REG_AW-1:0]          rd;
    logic [REG_AW-1:0]          rs1;
    logic [REG_AW-1:0]          rs2;
    logic [REG_AW-1:0]          rs3;
    logic [IMM_W-1:0]           imm;
    logic                       wb_valid;
    logic [REG_AW-1:0]          wb_rd;
    logic [XLEN-1:0]            wb_data;
    logic [CMP_W-1:0]           register_dump;

    logic [XLEN-1:0]            model [NUM_REGS];      // Architectural state after each issue
    logic [REG_AW-1:0]          exp_rd_q [$];
    logic [XLEN-1:0]            exp_data_q [$];
    logic                       issue_seen = 1'b0;
    logic [REG_AW-1:0]          mon_rd;
    logic [XLEN-1:0]            mon_data;
    int                         error_count = 0;
    int                         check_count = 0;

    exec_core #(.XLEN(XLEN)) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue         (issue),
        .op            (op),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .rs3           (rs3),
        .imm           (imm),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .register_dump (register_dump)
    );

    always #20 clk = ~clk;

    task automatic compare_value(input string what, input logic [CMP_W-1:0] got,
                                 input logic [CMP_W-1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    function automatic logic [XLEN-1:0] model_read(input logic [REG_AW-1:0] addr);
        return (addr == '0) ? '0 : model[addr];
    endfunction

    function automatic logic [XLEN-1:0] alu_expect(input op_e f_op, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b,
                                                   input logic [IMM_W-1:0] imm16);
        logic [XLEN-1:0] imm_sx;
        logic [4:0]      sh;
        logic [XLEN-1:0] r;
        imm_sx = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};
        sh = b[4:0];
        case (f_op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << sh;
            OP_SRL:  r = a >> sh;
            OP_SRA:  r = $unsigned($signed(a) >>> sh);
            OP_SLT:  r = ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
            OP_ADDI: r = a + imm_sx;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [XLEN-1:0] mac_expect(input op_e f_op, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b,
                                                   input logic [XLEN-1:0] c);
        logic [2*XLEN-1:0] full;
        logic [XLEN-1:0]   r;
        full = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (f_op)
            OP_MADD: r = full[XLEN-1:0] + c;
            OP_MSUB: r = c - full[XLEN-1:0];
            OP_CMOV: r = (c != '0) ? a : b;
            default: r = '0;
        endcase
        return r;
    endfunction

    // Called just after a rising edge, returns just after the next one
    task automatic issue_instr(input op_e i_op, input logic [REG_AW-1:0] dst,
                               input logic [REG_AW-1:0] src1, input logic [REG_AW-1:0] src2,
                               input logic [REG_AW-1:0] src3, input logic [IMM_W-1:0] i_imm);
        logic [XLEN-1:0] expected;
        if (is_mac_op(i_op)) begin
            expected = mac_expect(i_op, model_read(src1), model_read(src2), model_read(src3));
        end else begin
            expected = alu_expect(i_op, model_read(src1), model_read(src2), i_imm);
        end
        if (dst != '0) begin
            model[dst] = expected;
        end
        exp_rd_q.push_back(dst);
        exp_data_q.push_back(expected);
        issue = 1'b1;
        op    = i_op;
        rd    = dst;
        rs1   = src1;
        rs2   = src2;
        rs3   = src3;
        imm   = i_imm;
        @(posedge clk);
        #2;
    endtask

    task automatic wait_writebacks(input string phase);
        int cycles;
        cycles = 0;
        issue = 1'b0;
        while (exp_data_q.size() != 0 && cycles < WB_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (exp_data_q.size() != 0) begin
            error_count++;
            $display("Timeout: writeback never arrived during %s", phase);
            exp_rd_q.delete();
            exp_data_q.delete();
        end
    endtask

    task automatic compare_dump();
        logic [CMP_W-1:0] expected;
        for (int g = 0; g < DUMP_REGS; g++) begin
            expected[g*XLEN +: XLEN] = model[DUMP_BASE+g];
        end
        compare_value("register_dump", register_dump, expected);
    endtask

    always @(posedge clk) begin
        issue_seen <= issue & rst_n;
    end

    // Writeback monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            compare_value("wb_valid", CMP_W'(wb_valid), CMP_W'(issue_seen));
            if (wb_valid === 1'b1) begin
                if (exp_data_q.size() == 0) begin
                    error_count++;
                    $display("Writeback at %0t ns with no instruction outstanding", $time);
                end else begin
                    mon_rd   = exp_rd_q.pop_front();
                    mon_data = exp_data_q.pop_front();
                    compare_value("wb_rd", CMP_W'(wb_rd), CMP_W'(mon_rd));
                    compare_value("wb_data", CMP_W'(wb_data), CMP_W'(mon_data));
                end
            end
        end
    end

    task automatic check_reset_state();
        compare_value("register_dump after reset", register_dump, '0);
        compare_value("wb_valid after reset", CMP_W'(wb_valid), '0);
        compare_value("wb_rd after reset", CMP_W'(wb_rd), '0);
        compare_value("wb_data after reset", CMP_W'(wb_data), '0);
    endtask

    task automatic load_dump_registers();
        for (int r = DUMP_BASE; r < DUMP_BASE + DUMP_REGS; r++) begin
            issue_instr(OP_ADDI, REG_AW'(r), '0, '0, '0, IMM_W'($urandom));
        end
        wait_writebacks("immediate loads");
        compare_dump();
    endtask

    task automatic run_alu_ops();
        logic [REG_AW-1:0] src_a [4];
        logic [REG_AW-1:0] src_b [4];
        int n;
        src_a = '{5'd10, 5'd6, 5'd10, 5'd9};
        src_b = '{5'd6, 5'd7, 5'd8, 5'd10};
        n = 0;
        issue_instr(OP_ADDI, 5'd6, '0, '0, '0, IMM_W'($urandom) | 16'h8000);   // Negative
        issue_instr(OP_ADDI, 5'd7, '0, '0, '0, 16'd31);
        issue_instr(OP_ADDI, 5'd8, '0, '0, '0, 16'd45);                         // Above 31
        issue_instr(OP_ADDI, 5'd9, '0, '0, '0, (IMM_W'($urandom) & 16'h7fff) | 16'h0001);
        issue_instr(OP_ADDI, 5'd12, '0, '0, '0, 16'd16);
        // Full 32-bit random word in x10
        issue_instr(OP_ADDI, 5'd10, '0, '0, '0, IMM_W'($urandom));
        issue_instr(OP_SLL, 5'd10, 5'd10, 5'd12, '0, '0);
        issue_instr(OP_ADDI, 5'd10, 5'd10, '0, '0, IMM_W'($urandom));
        for (int k = 0; k <= 9; k++) begin
            for (int p = 0; p < 4; p++) begin
                issue_instr(op_e'(k), REG_AW'(20 + n % 8), src_a[p], src_b[p], '0,
                            IMM_W'($urandom));
                n++;
            end
        end
        wait_writebacks("ALU operations");
    endtask

    task automatic run_mac_ops();
        issue_instr(OP_MADD, 5'd21, 5'd10, 5'd6, 5'd9, '0);
        issue_instr(OP_MSUB, 5'd22, 5'd10, 5'd6, 5'd9, '0);
        issue_instr(OP_MADD, 5'd23, 5'd8, 5'd7, 5'd6, '0);
        issue_instr(OP_CMOV, 5'd24, 5'd10, 5'd6, 5'd0, '0);     // Zero c picks b
        issue_instr(OP_CMOV, 5'd25, 5'd10, 5'd6, 5'd9, '0);
        issue_instr(OP_CMOV, 5'd26, 5'd9, 5'd10, 5'd6, '0);
        wait_writebacks("MAC operations");
    endtask

    task automatic run_dependent_chain();
        logic [REG_AW-1:0] prev;
        logic [REG_AW-1:0] dst;
        prev = 5'd10;
        for (int i = 0; i < 12; i++) begin
            dst = REG_AW'(14 + i % 4);
            issue_instr(op_e'($urandom_range(0, 12)), dst, prev,
                        REG_AW'($urandom_range(6, 10)), prev, IMM_W'($urandom));
            prev = dst;
        end
        issue_instr(OP_ADD, 5'd3, prev, '0, '0, '0);
        wait_writebacks("dependent chain");
        compare_dump();
    endtask

    task automatic verify_x0_rule();
        issue_instr(OP_ADD, '0, 5'd10, 5'd6, '0, '0);
        issue_instr(OP_ADD, 5'd2, '0, 5'd9, '0, '0);            // Same cycle as the dropped write
        issue_instr(OP_ADDI, '0, 5'd9, '0, '0, IMM_W'($urandom));
        issue_instr(OP_MADD, '0, 5'd10, 5'd9, 5'd6, '0);
        issue_instr(OP_ADD, 5'd4, '0, '0, '0, '0);
        wait_writebacks("x0 writes");
        issue_instr(OP_ADD, 5'd5, '0, '0, '0, '0);
        wait_writebacks("x0 reads");
        compare_dump();
    endtask

    initial begin
        void'($urandom(32'hbeac));
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        rst_n = 1'b0;
        issue = 1'b0;
        op    = OP_ADD;
        rd    = '0;
        rs1   = '0;
        rs2   = '0;
        rs3   = '0;
        imm   = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_reset_state();
        load_dump_registers();
        run_alu_ops();
        run_mac_ops();
        run_dependent_chain();
        verify_x0_rule();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
